//--- files.f
hw/cpuPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/idExReg.sv
hw/executeStage.sv
hw/memArbiter.sv
hw/memWbStage.sv
hw/cpuTop.sv
sim/cpuTb_chk.sv
sim/cpuTb.sv

//--- hw/cpuPkg.sv
package cpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] regIdx_t;
	typedef logic [7:0] memAddr_t;
	typedef logic [15:0] ctrl_t;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_XOR = 4'h3,
		OP_ADDI = 4'h4,
		OP_LD = 4'h5,
		OP_ST = 4'h6,
		OP_BEQZ = 4'h7,
		OP_HALT = 4'h8
	} opcode_t;

	////////////////////
	// Control word bit positions.
	localparam int CTRL_REGWRITE = 0;
	localparam int CTRL_MEMEN = 1;
	localparam int CTRL_MEMWRITE = 2;
	localparam int CTRL_MEMTOREG = 3;
	localparam int CTRL_BRANCH = 4;
	localparam int CTRL_IMMSRC = 5;
	localparam int CTRL_HALT = 6;
	localparam int CTRL_ALUOP_LO = 7;
	localparam int CTRL_ALUOP_HI = 8;

	// Bits dropped when a slot turns into a bubble.
	localparam ctrl_t CTRL_KILL_MASK = ctrl_t'((1 << CTRL_REGWRITE) | (1 << CTRL_MEMEN) |
		(1 << CTRL_MEMWRITE) | (1 << CTRL_MEMTOREG) | (1 << CTRL_BRANCH) | (1 << CTRL_HALT));

	localparam logic [1:0] ALU_ADD = 2'd0;
	localparam logic [1:0] ALU_SUB = 2'd1;
	localparam logic [1:0] ALU_AND = 2'd2;
	localparam logic [1:0] ALU_XOR = 2'd3;

	////////////////////
	// Instruction fields.
	localparam int OPC_LO = 12;
	localparam int RD_LO = 9;
	localparam int RS_LO = 6;
	localparam int RT_LO = 3;
	localparam int IMM_BITS = 6;

	localparam int MEM_WORDS = 256;
	localparam int DATA_BASE_BIT = 7;

endpackage

//--- hw/cpuTop.sv
module cpuTop (
	input logic clk,
	input logic rst,
	input logic start,
	input logic loadEn,
	input cpuPkg::memAddr_t loadAddr,
	input cpuPkg::word_t loadData,
	output logic wbValid,
	output cpuPkg::regIdx_t wbReg,
	output cpuPkg::word_t wbData,
	output logic storeValid,
	output cpuPkg::memAddr_t storeAddr,
	output cpuPkg::word_t storeData,
	output logic halted,
	output logic err
);
	import cpuPkg::*;

	logic fetchReq, fetchGnt, instrValid, ifValid;
	memAddr_t fetchAddr, ifPcNext;
	word_t instr, ifInstr;

	logic stall, halt, idValid, idErr;
	ctrl_t idCtrl;
	memAddr_t idPcNext;
	regIdx_t idDest;
	word_t readData1, readData2, immExt;

	ctrl_t ieCtrl;
	memAddr_t iePcNext;
	regIdx_t ieDest;
	word_t ieRd1, ieRd2, ieImm;
	logic ieValid, ieErr;

	logic redirect, exWrite, mValid, mErr;
	memAddr_t redirectPc;
	regIdx_t exDest, mDest;
	ctrl_t mCtrl;
	word_t mResult, mStoreData;

	logic dataReq, dataWe, dataRvalid, memWrite;
	memAddr_t dataAddr;
	word_t dataWdata, dataRdata;
	regIdx_t memDest;

	////////////////////
	fetchStage fetchStage_i (
		.clk(clk), .rst(rst), .start(start), .stall(stall), .halt(halt),
		.redirect(redirect), .redirectPc(redirectPc),
		.fetchGnt(fetchGnt), .instrValid(instrValid), .instr(instr),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr),
		.ifValid(ifValid), .ifInstr(ifInstr), .ifPcNext(ifPcNext)
	);

	decodeStage decodeStage_i (
		.clk(clk), .rst(rst), .ifValid(ifValid), .ifInstr(ifInstr), .ifPcNext(ifPcNext),
		.wbEn(wbValid), .wbReg(wbReg), .wbData(wbData),
		.exDest(exDest), .exWrite(exWrite), .memDest(memDest), .memWrite(memWrite),
		.flush(redirect), .stall(stall), .halt(halt), .idValid(idValid), .idErr(idErr),
		.ctrl(idCtrl), .idPcNext(idPcNext), .idDest(idDest),
		.readData1(readData1), .readData2(readData2), .immExt(immExt)
	);

	idExReg idExReg_i (
		.clk(clk), .rst(rst), .flush(redirect), .inValid(idValid),
		.ctrlIn(idCtrl), .pcNextIn(idPcNext), .destIn(idDest),
		.readData1In(readData1), .readData2In(readData2), .immExtIn(immExt), .errIn(idErr),
		.ctrlOut(ieCtrl), .pcNextOut(iePcNext), .destOut(ieDest),
		.readData1Out(ieRd1), .readData2Out(ieRd2), .immExtOut(ieImm),
		.validOut(ieValid), .errOut(ieErr)
	);

	executeStage executeStage_i (
		.clk(clk), .rst(rst), .ctrl(ieCtrl), .pcNext(iePcNext), .dest(ieDest),
		.readData1(ieRd1), .readData2(ieRd2), .immExt(ieImm), .valid(ieValid), .err(ieErr),
		.redirect(redirect), .redirectPc(redirectPc), .exDest(exDest), .exWrite(exWrite),
		.mValid(mValid), .mCtrl(mCtrl), .mResult(mResult), .mStoreData(mStoreData),
		.mDest(mDest), .mErr(mErr)
	);

	memArbiter memArbiter_i (
		.clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr), .dataWdata(dataWdata),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr), .fetchGnt(fetchGnt),
		.instrValid(instrValid), .instr(instr),
		.dataRvalid(dataRvalid), .dataRdata(dataRdata)
	);

	memWbStage memWbStage_i (
		.clk(clk), .rst(rst), .mValid(mValid), .mCtrl(mCtrl), .mResult(mResult),
		.mStoreData(mStoreData), .mDest(mDest), .mErr(mErr),
		.dataRvalid(dataRvalid), .dataRdata(dataRdata),
		.dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr), .dataWdata(dataWdata),
		.memDest(memDest), .memWrite(memWrite),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.halted(halted), .err(err)
	);

endmodule

//--- hw/decodeStage.sv
module decodeStage (
	input logic clk,
	input logic rst,
	input logic ifValid,
	input cpuPkg::word_t ifInstr,
	input cpuPkg::memAddr_t ifPcNext,
	input logic wbEn,
	input cpuPkg::regIdx_t wbReg,
	input cpuPkg::word_t wbData,
	input cpuPkg::regIdx_t exDest,
	input logic exWrite,
	input cpuPkg::regIdx_t memDest,
	input logic memWrite,
	input logic flush,
	output logic stall,
	output logic halt,
	output logic idValid,
	output logic idErr,
	output cpuPkg::ctrl_t ctrl,
	output cpuPkg::memAddr_t idPcNext,
	output cpuPkg::regIdx_t idDest,
	output cpuPkg::word_t readData1,
	output cpuPkg::word_t readData2,
	output cpuPkg::word_t immExt
);
	import cpuPkg::*;

	word_t regs [8];
	opcode_t op;
	regIdx_t rd, rs, rt, src2;
	logic useRs, useSrc2, illegal, hazard;

	function automatic logic busy(regIdx_t r);
		return (exWrite && exDest == r) || (memWrite && memDest == r);
	endfunction

	assign op = opcode_t'(ifInstr[OPC_LO +: 4]);
	assign rd = ifInstr[RD_LO +: 3];
	assign rs = ifInstr[RS_LO +: 3];
	assign rt = ifInstr[RT_LO +: 3];

	// Store data comes from rd.
	assign src2 = (op == OP_ST) ? rd : rt;

	always_comb begin
		ctrl = '0;
		useRs = 1'b0;
		useSrc2 = 1'b0;
		illegal = 1'b0;
		ctrl[CTRL_ALUOP_HI:CTRL_ALUOP_LO] = ALU_ADD;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
				ctrl[CTRL_REGWRITE] = 1'b1;
				useRs = 1'b1;
				useSrc2 = 1'b1;
				if (op == OP_SUB)
					ctrl[CTRL_ALUOP_HI:CTRL_ALUOP_LO] = ALU_SUB;
				else if (op == OP_AND)
					ctrl[CTRL_ALUOP_HI:CTRL_ALUOP_LO] = ALU_AND;
				else if (op == OP_XOR)
					ctrl[CTRL_ALUOP_HI:CTRL_ALUOP_LO] = ALU_XOR;
			end
			OP_ADDI: begin
				ctrl[CTRL_REGWRITE] = 1'b1;
				ctrl[CTRL_IMMSRC] = 1'b1;
				useRs = 1'b1;
			end
			OP_LD: begin
				ctrl[CTRL_REGWRITE] = 1'b1;
				ctrl[CTRL_MEMEN] = 1'b1;
				ctrl[CTRL_MEMTOREG] = 1'b1;
				ctrl[CTRL_IMMSRC] = 1'b1;
				useRs = 1'b1;
			end
			OP_ST: begin
				ctrl[CTRL_MEMEN] = 1'b1;
				ctrl[CTRL_MEMWRITE] = 1'b1;
				ctrl[CTRL_IMMSRC] = 1'b1;
				useRs = 1'b1;
				useSrc2 = 1'b1;
			end
			OP_BEQZ: begin
				ctrl[CTRL_BRANCH] = 1'b1;
				useRs = 1'b1;
			end
			OP_HALT: ctrl[CTRL_HALT] = 1'b1;
			default: begin
				ctrl[CTRL_HALT] = 1'b1;
				illegal = 1'b1;
			end
		endcase
	end

	////////////////////
	// Interlock against writers still in execute or memory.
	assign hazard = (useRs && busy(rs)) || (useSrc2 && busy(src2));
	assign stall = ifValid && !flush && hazard;
	assign halt = ifValid && !flush && ctrl[CTRL_HALT];
	assign idValid = ifValid && !flush && !stall;
	assign idErr = illegal;

	assign idPcNext = ifPcNext;
	assign idDest = rd;
	assign immExt = {{($bits(word_t) - IMM_BITS){ifInstr[IMM_BITS-1]}}, ifInstr[IMM_BITS-1:0]};

	// Writeback lands in the same cycle it is read.
	assign readData1 = (wbEn && wbReg == rs) ? wbData : regs[rs];
	assign readData2 = (wbEn && wbReg == src2) ? wbData : regs[src2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wbEn) begin
			regs[wbReg] <= wbData;
		end
	end

endmodule

//--- hw/executeStage.sv
module executeStage (
	input logic clk,
	input logic rst,
	input cpuPkg::ctrl_t ctrl,
	input cpuPkg::memAddr_t pcNext,
	input cpuPkg::regIdx_t dest,
	input cpuPkg::word_t readData1,
	input cpuPkg::word_t readData2,
	input cpuPkg::word_t immExt,
	input logic valid,
	input logic err,
	output logic redirect,
	output cpuPkg::memAddr_t redirectPc,
	output cpuPkg::regIdx_t exDest,
	output logic exWrite,
	output logic mValid,
	output cpuPkg::ctrl_t mCtrl,
	output cpuPkg::word_t mResult,
	output cpuPkg::word_t mStoreData,
	output cpuPkg::regIdx_t mDest,
	output logic mErr
);
	import cpuPkg::*;

	word_t aluB, aluOut, result;
	memAddr_t addr;

	assign aluB = ctrl[CTRL_IMMSRC] ? immExt : readData2;

	always_comb begin
		case (ctrl[CTRL_ALUOP_HI:CTRL_ALUOP_LO])
			ALU_SUB: aluOut = readData1 - aluB;
			ALU_AND: aluOut = readData1 & aluB;
			ALU_XOR: aluOut = readData1 ^ aluB;
			default: aluOut = readData1 + aluB;
		endcase
	end

	// Data accesses always fall in the upper half of memory.
	assign addr = memAddr_t'(aluOut) | memAddr_t'(1 << DATA_BASE_BIT);
	assign result = ctrl[CTRL_MEMEN] ? word_t'(addr) : aluOut;

	////////////////////
	// Branch resolution.
	assign redirect = valid && ctrl[CTRL_BRANCH] && (readData1 == '0);
	assign redirectPc = pcNext + memAddr_t'(immExt);

	assign exDest = dest;
	assign exWrite = valid && ctrl[CTRL_REGWRITE];

	always_ff @(posedge clk) begin
		if (rst) begin
			mValid <= 1'b0;
			mCtrl <= '0;
			mErr <= 1'b0;
		end else begin
			mValid <= valid;
			mCtrl <= ctrl;
			mErr <= err;
		end
	end

	always_ff @(posedge clk) begin
		mResult <= result;
		mStoreData <= readData2;
		mDest <= dest;
	end

endmodule

//--- hw/fetchStage.sv
module fetchStage (
	input logic clk,
	input logic rst,
	input logic start,
	input logic stall,
	input logic halt,
	input logic redirect,
	input cpuPkg::memAddr_t redirectPc,
	input logic fetchGnt,
	input logic instrValid,
	input cpuPkg::word_t instr,
	output logic fetchReq,
	output cpuPkg::memAddr_t fetchAddr,
	output logic ifValid,
	output cpuPkg::word_t ifInstr,
	output cpuPkg::memAddr_t ifPcNext
);
	import cpuPkg::*;

	memAddr_t pc;
	logic running;
	logic take;

	// A return that meets a redirect belongs to the flushed path.
	assign take = instrValid && !redirect;

	// One fetch in flight, and only when the decode slot will be free for it.
	assign fetchReq = running && !redirect && !halt && !instrValid && (!ifValid || !stall);
	assign fetchAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			pc <= '0;
		end else begin
			if (start)
				running <= 1'b1;
			else if (halt)
				running <= 1'b0;
			if (start)
				pc <= '0;
			else if (redirect)
				pc <= redirectPc;
			else if (fetchReq && fetchGnt)
				pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || redirect)
			ifValid <= 1'b0;
		else if (take)
			ifValid <= 1'b1;
		else if (!stall)
			ifValid <= 1'b0;
	end

	// The PC already points past the returned word.
	always_ff @(posedge clk) begin
		if (take) begin
			ifInstr <= instr;
			ifPcNext <= pc;
		end
	end

endmodule

//--- hw/idExReg.sv
module idExReg (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic inValid,
	input cpuPkg::ctrl_t ctrlIn,
	input cpuPkg::memAddr_t pcNextIn,
	input cpuPkg::regIdx_t destIn,
	input cpuPkg::word_t readData1In,
	input cpuPkg::word_t readData2In,
	input cpuPkg::word_t immExtIn,
	input logic errIn,
	output cpuPkg::ctrl_t ctrlOut,
	output cpuPkg::memAddr_t pcNextOut,
	output cpuPkg::regIdx_t destOut,
	output cpuPkg::word_t readData1Out,
	output cpuPkg::word_t readData2Out,
	output cpuPkg::word_t immExtOut,
	output logic validOut,
	output logic errOut
);
	import cpuPkg::*;

	logic kill;

	// Reset, flush and an empty decode slot all leave a bubble.
	assign kill = rst || flush || !inValid;

	always_ff @(posedge clk) begin
		if (kill) begin
			ctrlOut <= ctrlIn & ~CTRL_KILL_MASK;
			validOut <= 1'b0;
			errOut <= 1'b0;
		end else begin
			ctrlOut <= ctrlIn;
			validOut <= 1'b1;
			errOut <= errIn;
		end
	end

	always_ff @(posedge clk) begin
		pcNextOut <= pcNextIn;
		destOut <= destIn;
		readData1Out <= readData1In;
		readData2Out <= readData2In;
		immExtOut <= immExtIn;
	end

endmodule

//--- hw/memArbiter.sv
module memArbiter (
	input logic clk,
	input logic loadEn,
	input cpuPkg::memAddr_t loadAddr,
	input cpuPkg::word_t loadData,
	input logic dataReq,
	input logic dataWe,
	input cpuPkg::memAddr_t dataAddr,
	input cpuPkg::word_t dataWdata,
	input logic fetchReq,
	input cpuPkg::memAddr_t fetchAddr,
	output logic fetchGnt,
	output logic instrValid,
	output cpuPkg::word_t instr,
	output logic dataRvalid,
	output cpuPkg::word_t dataRdata
);
	import cpuPkg::*;

	word_t mem [MEM_WORDS];
	word_t rdData;
	memAddr_t rdAddr;

	// Fixed priority: program load, then data, then fetch.
	assign fetchGnt = fetchReq && !loadEn && !dataReq;
	assign rdAddr = dataReq ? dataAddr : fetchAddr;

	always_ff @(posedge clk) begin
		if (loadEn)
			mem[loadAddr] <= loadData;
		else if (dataReq && dataWe)
			mem[dataAddr] <= dataWdata;
	end

	////////////////////
	// Registered read, returned to whoever won.
	always_ff @(posedge clk) begin
		dataRvalid <= dataReq && !dataWe && !loadEn;
		instrValid <= fetchGnt;
		rdData <= mem[rdAddr];
	end

	assign instr = rdData;
	assign dataRdata = rdData;

endmodule

//--- hw/memWbStage.sv
module memWbStage (
	input logic clk,
	input logic rst,
	input logic mValid,
	input cpuPkg::ctrl_t mCtrl,
	input cpuPkg::word_t mResult,
	input cpuPkg::word_t mStoreData,
	input cpuPkg::regIdx_t mDest,
	input logic mErr,
	input logic dataRvalid,
	input cpuPkg::word_t dataRdata,
	output logic dataReq,
	output logic dataWe,
	output cpuPkg::memAddr_t dataAddr,
	output cpuPkg::word_t dataWdata,
	output cpuPkg::regIdx_t memDest,
	output logic memWrite,
	output logic wbValid,
	output cpuPkg::regIdx_t wbReg,
	output cpuPkg::word_t wbData,
	output logic storeValid,
	output cpuPkg::memAddr_t storeAddr,
	output cpuPkg::word_t storeData,
	output logic halted,
	output logic err
);
	import cpuPkg::*;

	regIdx_t ldDest;
	logic aluCommit;

	assign dataReq = mValid && mCtrl[CTRL_MEMEN];
	assign dataWe = mCtrl[CTRL_MEMWRITE];
	assign dataAddr = memAddr_t'(mResult);
	assign dataWdata = mStoreData;

	assign memDest = mDest;
	assign memWrite = mValid && mCtrl[CTRL_REGWRITE];

	// ALU results commit now, loads when their data returns.
	assign aluCommit = memWrite && !mCtrl[CTRL_MEMTOREG];
	assign wbValid = aluCommit || dataRvalid;
	assign wbReg = dataRvalid ? ldDest : mDest;
	assign wbData = dataRvalid ? dataRdata : mResult;

	assign storeValid = dataReq && dataWe;
	assign storeAddr = dataAddr;
	assign storeData = mStoreData;

	always_ff @(posedge clk) begin
		if (dataReq && !dataWe)
			ldDest <= mDest;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
			err <= 1'b0;
		end else if (mValid && mCtrl[CTRL_HALT] && !halted) begin
			halted <= 1'b1;
			err <= mErr;
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the cpuTop regression with Verilator and runs it.
# The exit status is the simulator's own, non-zero on any failure.
set -e

cd "$(dirname "$0")"

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator was not found in PATH" >&2
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cpuTb -Mdir obj_dir -f files.f

./obj_dir/VcpuTb

//--- sim/cpuTb.sv
module cpuTb;
	timeunit 1ns;
	timeprecision 1ps;
	import cpuPkg::*;

	localparam int PERIOD = 8;
	localparam int NUM_PROGS = 20;
	localparam int MAX_LEN = 100;
	localparam int CYCLES_PER_INSTR = 12;
	// Reset, program words, data window and a few idle cycles per program.
	localparam int LOAD_CYCLES = MAX_LEN + 128 + 8;
	localparam int WATCHDOG_NS = NUM_PROGS * (MAX_LEN * CYCLES_PER_INSTR + LOAD_CYCLES) * PERIOD;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic loadEn;
	memAddr_t loadAddr;
	word_t loadData;
	logic wbValid;
	regIdx_t wbReg;
	word_t wbData;
	logic storeValid;
	memAddr_t storeAddr;
	word_t storeData;
	logic halted;
	logic err;

	integer seed;
	word_t prog [128];
	word_t dmem [256];
	int progLen;
	int commitCount;
	// Expected commits as {isStore, reg or address, data}.
	logic [24:0] expQ [$];

	cpuTop cpuTop_i (
		.clk(clk), .rst(rst), .start(start),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.halted(halted), .err(err)
	);

	always #(PERIOD / 2) clk = ~clk;

	////////////////////
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected)
			abortRun($sformatf("error at %0d ns: %s is %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	function automatic int unsigned pickBelow(input int unsigned n);
		int unsigned r;
		r = $random(seed);
		return r % n;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic writeWord(input memAddr_t a, input word_t d);
		loadEn = 1'b1;
		loadAddr = a;
		loadData = d;
		tick();
		loadEn = 1'b0;
	endtask

	////////////////////
	// Random program. Branches only jump forward and never past the last word.
	task automatic buildProgram(input int progNo);
		int i;
		int sel;
		int maxImm;
		regIdx_t rd, rs, rt;
		logic [5:0] imm6;
		opcode_t op;
		progLen = 8 + int'(pickBelow(MAX_LEN - 7));
		i = 0;
		while (i < progLen - 1) begin
			sel = int'(pickBelow(10));
			rd = regIdx_t'(pickBelow(8));
			rs = regIdx_t'(pickBelow(8));
			rt = regIdx_t'(pickBelow(8));
			imm6 = 6'(pickBelow(64));
			if (sel < 4) begin
				op = (sel == 0) ? OP_ADD : (sel == 1) ? OP_SUB : (sel == 2) ? OP_AND : OP_XOR;
				prog[i] = {op, rd, rs, rt, 3'b000};
			end else if (sel == 4 || sel == 5 || sel == 9) begin
				prog[i] = {OP_ADDI, rd, rs, imm6};
			end else if (sel == 6) begin
				prog[i] = {OP_LD, rd, rs, imm6};
			end else if (sel == 7) begin
				prog[i] = {OP_ST, rd, rs, imm6};
				// Often read the same word straight back.
				if (i + 1 < progLen - 1 && pickBelow(2) == 0) begin
					i = i + 1;
					prog[i] = {OP_LD, rt, rs, imm6};
				end
			end else begin
				maxImm = progLen - 2 - i;
				if (maxImm > 31)
					maxImm = 31;
				imm6 = 6'(pickBelow(32'(maxImm + 1)));
				prog[i] = {OP_BEQZ, rd, rs, imm6};
			end
			i = i + 1;
		end
		if (progNo % 4 == 3)
			prog[progLen - 1] = {4'(9 + pickBelow(7)), 12'h000};
		else
			prog[progLen - 1] = {OP_HALT, 12'h000};
	endtask

	////////////////////
	// Instruction-set model. Fills expQ and returns the expected err flag.
	task automatic runModel(output logic expErr);
		word_t r [8];
		word_t w, imm, sum;
		memAddr_t addr, tgt;
		regIdx_t rd, rs, rt;
		int pc, steps, k;
		logic done;
		for (k = 0; k < 8; k++)
			r[k] = '0;
		expQ.delete();
		pc = 0;
		steps = 0;
		done = 1'b0;
		expErr = 1'b0;
		while (!done) begin
			if (steps >= 128 || pc >= progLen)
				abortRun("the generated program runs past its last instruction");
			w = prog[pc];
			rd = w[11:9];
			rs = w[8:6];
			rt = w[5:3];
			imm = {{10{w[5]}}, w[5:0]};
			sum = r[rs] + imm;
			addr = sum[7:0] | 8'h80;
			pc = pc + 1;
			steps = steps + 1;
			case (w[15:12])
				OP_ADD: r[rd] = r[rs] + r[rt];
				OP_SUB: r[rd] = r[rs] - r[rt];
				OP_AND: r[rd] = r[rs] & r[rt];
				OP_XOR: r[rd] = r[rs] ^ r[rt];
				OP_ADDI: r[rd] = sum;
				OP_LD: r[rd] = dmem[addr];
				OP_ST: dmem[addr] = r[rd];
				OP_BEQZ: begin
					if (r[rs] == '0) begin
						tgt = 8'(pc) + imm[7:0];
						pc = int'(tgt);
					end
				end
				OP_HALT: done = 1'b1;
				default: begin
					done = 1'b1;
					expErr = 1'b1;
				end
			endcase
			if (w[15:12] == OP_ST)
				expQ.push_back({1'b1, addr, r[rd]});
			else if (!done && w[15:12] != OP_BEQZ)
				expQ.push_back({1'b0, 5'b00000, rd, r[rd]});
		end
	endtask

	task automatic runProgram(input int progNo);
		logic expErr;
		int a;
		rst = 1'b1;
		repeat (2) tick();
		rst = 1'b0;
		compareValue(32'(halted), 32'(1'b0), "halted after reset");
		compareValue(32'(err), 32'(1'b0), "err after reset");
		buildProgram(progNo);
		for (a = 0; a < progLen; a++)
			writeWord(8'(a), prog[a]);
		for (a = 128; a < 256; a++) begin
			writeWord(8'(a), '0);
			dmem[a] = '0;
		end
		runModel(expErr);
		start = 1'b1;
		tick();
		start = 1'b0;
		while (!halted)
			tick();
		compareValue(32'(err), 32'(expErr), "err at halt");
		compareValue(32'(expQ.size()), 32'd0, "commits still missing at halt");
		repeat (4) tick();
		compareValue(32'(halted), 32'(1'b1), "halted held after the run");
	endtask

	////////////////////
	// Commit monitor samples away from the clock edge.
	always @(negedge clk) begin : commitMonitor
		logic [24:0] e;
		if (!rst && (wbValid || storeValid)) begin
			if (expQ.size() == 0) begin
				abortRun("a commit appeared that the model did not expect");
			end else begin
				e = expQ.pop_front();
				commitCount = commitCount + 1;
				compareValue(32'(storeValid), 32'(e[24]), "commit is a store");
				if (storeValid) begin
					compareValue(32'(storeAddr), 32'(e[23:16]), "storeAddr");
					compareValue(32'(storeData), 32'(e[15:0]), "storeData");
				end else begin
					compareValue(32'(wbReg), 32'(e[23:16]), "wbReg");
					compareValue(32'(wbData), 32'(e[15:0]), "wbData");
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		abortRun($sformatf("timeout: the core never halted within %0d ns", WATCHDOG_NS));
	end

	initial begin : mainFlow
		int p;
		seed = 32'he85b_4948;
		rst = 1'b1;
		start = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		commitCount = 0;
		for (p = 0; p < NUM_PROGS; p++)
			runProgram(p);
		if (commitCount > 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			abortRun("no instruction committed in the whole regression");
		end
	end

endmodule

//--- sim/cpuTb_chk.sv
module cpuTbChk (
	input logic clk,
	input logic rst,
	input logic start,
	input logic loadEn,
	input logic wbValid,
	input logic storeValid,
	input logic halted,
	input logic fetchReq,
	input cpuPkg::memAddr_t fetchAddr,
	input logic instrValid,
	input logic dataReq
);
	timeunit 1ns;
	timeprecision 1ps;

	logic running;

	// Core counts as running from the start strobe until it halts.
	always_ff @(posedge clk) begin
		if (rst)
			running <= 1'b0;
		else if (start)
			running <= 1'b1;
		else if (halted)
			running <= 1'b0;
	end

	////////////////////
	singleCommit: assert property (@(posedge clk) disable iff (rst)
		!(wbValid && storeValid))
		else $error("wbValid and storeValid were high in the same cycle");

	quietAfterHalt: assert property (@(posedge clk) disable iff (rst)
		halted |-> !(wbValid || storeValid))
		else $error("a commit strobe appeared after halted");

	loadWhileIdle: assert property (@(posedge clk) disable iff (rst)
		running |-> !loadEn)
		else $error("loadEn was driven while the core was running");

	// A fetch that meets a data request returns nothing and waits at the same address.
	dataBeatsFetch: assert property (@(posedge clk) disable iff (rst)
		(fetchReq && dataReq) |=> (!instrValid && $stable(fetchAddr)))
		else $error("a fetch went ahead of a data request");

endmodule

bind cpuTop cpuTbChk cpuTbChk_i (
	.clk(clk),
	.rst(rst),
	.start(start),
	.loadEn(loadEn),
	.wbValid(wbValid),
	.storeValid(storeValid),
	.halted(halted),
	.fetchReq(fetchReq),
	.fetchAddr(fetchAddr),
	.instrValid(instrValid),
	.dataReq(dataReq)
);
